// ==== design/gpuMacros_macros.svh ====
`ifndef GPU_MACROS_SVH
`define GPU_MACROS_SVH

// bus widths
`define REG_ADDR_W      4       // apb register offset
`define DATA_W          8       // host registers and vmem bytes
`define VMEM_ADDR_W     16      // vmem and frame buffer addresses
`define FB_DATA_W       16      // eight 2-bit shades per frame word

// background geometry
`define TILES_PER_ROW   32      // map columns per line
`define LINES_PER_FRAME 256     // lines walked before wrapping
`define FIFO_DEPTH      4       // tile-row pairs buffered ahead of the mapper

// vram layout
`define MAP_BASE0       16'h9800  // lcdc[6] clear
`define MAP_BASE1       16'h9C00  // lcdc[6] set
`define TILE_BASE1      16'h8000  // lcdc[4] set, unsigned tile index
`define TILE_BASE0      16'h9000  // lcdc[4] clear, signed tile index

`endif

// ==== design/gpuPkg.sv ====
`include "gpuMacros_macros.svh"

package gpuPkg;

  // apb register offsets
  // offsets 5 and 6 and 8 up are holes and answer with an error
  typedef enum logic [`REG_ADDR_W-1:0] {
    regLcdc = 0,  // lcd control
    regStat = 1,  // fetcher state, read only
    regScy  = 2,  // scroll y
    regScx  = 3,  // scroll x
    regLy   = 4,  // current line, read only
    regBgp  = 7   // background palette
  } regAddrE;

  // background fetch walk, one vmem read per two cycles
  typedef enum logic [2:0] {
    fetchIdle     = 3'd0,  // lcd off or waiting for lcdc[7]
    fetchReadMap  = 3'd1,  // tile index from the map
    fetchReadLow  = 3'd2,  // low bitplane of the tile row
    fetchReadHigh = 3'd3,  // high bitplane
    fetchPush     = 3'd4   // offer the pair downstream
  } fetchStateE;

endpackage

// ==== design/tileRowIf.sv ====
`timescale 1ns/1ps
`include "gpuMacros_macros.svh"

// one 8-pixel background word as two bitplanes plus its frame index
interface tileRowIf;

  logic                    valid;     // pair offered
  logic                    ready;     // pair accepted on this edge when valid
  logic [`DATA_W-1:0]      tileLow;   // bitplane 0
  logic [`DATA_W-1:0]      tileHigh;  // bitplane 1
  logic [`VMEM_ADDR_W-1:0] fbAddr;    // line * 32 + column

  modport source
  (
    output valid, tileLow, tileHigh, fbAddr,
    input  ready
  );

  modport sink
  (
    input  valid, tileLow, tileHigh, fbAddr,
    output ready
  );

endinterface

// ==== design/gpuRegisters.sv ====
`timescale 1ns/1ps
`include "gpuMacros_macros.svh"

module gpuRegisters
  import gpuPkg::*;
(
  input  logic               clock,
  input  logic               reset,
  // apb slave
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  regAddrE            paddr,
  input  logic [`DATA_W-1:0] pwdata,
  output logic [`DATA_W-1:0] prdata,
  output logic               pready,
  output logic               pslverr,
  // control registers to the pipeline
  output logic [`DATA_W-1:0] lcdc,
  output logic [`DATA_W-1:0] scy,
  output logic [`DATA_W-1:0] scx,
  output logic [`DATA_W-1:0] bgp,
  // status back from the fetcher
  input  fetchStateE         state,
  input  logic [`DATA_W-1:0] ly
);

  logic access;    // apb access phase
  logic mapped;    // offset hits a register
  logic writable;  // offset hits host storage
  logic regWe;

  assign access  = psel & penable;
  assign pready  = 1'b1;  // every access closes in its access phase
  assign regWe   = access & pwrite & writable;
  assign pslverr = access & (pwrite ? ~writable : ~mapped);

  //////////////////////////////////////////////////
  // address decode and read mux
  //////////////////////////////////////////////////
  always_comb
  begin
    mapped   = 1'b1;
    writable = 1'b0;
    prdata   = '0;
    case (paddr)
      regLcdc:
      begin
        writable = 1'b1;
        prdata   = lcdc;
      end
      regStat: prdata = {{(`DATA_W - $bits(fetchStateE)){1'b0}}, state};  // zero padded
      regScy:
      begin
        writable = 1'b1;
        prdata   = scy;
      end
      regScx:
      begin
        writable = 1'b1;
        prdata   = scx;
      end
      regLy:   prdata = ly;  // live line count
      regBgp:
      begin
        writable = 1'b1;
        prdata   = bgp;
      end
      default: mapped = 1'b0;  // hole in the map
    endcase
  end

  // host writable registers
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      lcdc <= '0;
      scy  <= '0;
      scx  <= '0;
      bgp  <= '0;
    end
    else if (regWe)
    begin
      case (paddr)
        regLcdc: lcdc <= pwdata;
        regScy:  scy  <= pwdata;
        regScx:  scx  <= pwdata;
        regBgp:  bgp  <= pwdata;
        default: ;
      endcase
    end
  end

  // an error response belongs to an access phase that followed its setup phase
  apbErrPhase: assert property (@(posedge clock) disable iff (reset)
    pslverr |-> access && $past(psel && !penable));

endmodule

// ==== design/tileFetcher.sv ====
`timescale 1ns/1ps
`include "gpuMacros_macros.svh"

module tileFetcher
  import gpuPkg::*;
(
  input  logic                    clock,
  input  logic                    reset,
  input  logic [`DATA_W-1:0]      lcdc,
  input  logic [`DATA_W-1:0]      scy,
  input  logic [`DATA_W-1:0]      scx,
  // video memory read port
  output logic                    vmemRead,
  output logic [`VMEM_ADDR_W-1:0] vmemAddr,
  input  logic [`DATA_W-1:0]      vmemData,   // valid the cycle after vmemRead
  tileRowIf.source                rowOut,
  output fetchStateE              state,
  output logic [`DATA_W-1:0]      ly
);

  localparam int COL_W = $clog2(`TILES_PER_ROW);

  logic [COL_W-1:0]        column;     // tile column on the current line
  logic                    phase;      // low issues the read and high captures it
  logic [`DATA_W-1:0]      tileIndex;  // map entry
  logic [`DATA_W-1:0]      lowByte;
  logic [`DATA_W-1:0]      highByte;
  logic [COL_W-1:0]        mapRow;
  logic [COL_W-1:0]        mapCol;
  logic [`VMEM_ADDR_W-1:0] mapAddr;
  logic [`VMEM_ADDR_W-1:0] tileAddr;
  logic [`VMEM_ADDR_W-1:0] rowAddr;
  logic                    pushDone;
  logic                    lastCol;
  logic                    lastLine;

  //////////////////////////////////////////////////
  // vram address generation
  //////////////////////////////////////////////////
  assign mapRow  = ly[7:3] + scy[7:3];  // wraps at 32 rows
  assign mapCol  = column + scx[7:3];   // wraps at 32 columns
  assign mapAddr = (lcdc[6] ? `MAP_BASE1 : `MAP_BASE0)
                 + {{(`VMEM_ADDR_W - 2*COL_W){1'b0}}, mapRow, mapCol};

  // 16 bytes per tile, set 0 indexes signed around 0x9000
  assign tileAddr = lcdc[4] ? `TILE_BASE1 + {4'b0, tileIndex, 4'b0}
                            : `TILE_BASE0 + {{4{tileIndex[7]}}, tileIndex, 4'b0};
  assign rowAddr  = tileAddr + {12'b0, ly[2:0], 1'b0};  // two bytes per pixel row

  always_comb
  begin
    case (state)
      fetchReadLow:  vmemAddr = rowAddr;
      fetchReadHigh: vmemAddr = rowAddr + 1'b1;  // high plane follows low
      default:       vmemAddr = mapAddr;
    endcase
  end

  assign vmemRead = ~phase & (state inside {fetchReadMap, fetchReadLow, fetchReadHigh});

  // downstream pair
  assign rowOut.valid    = (state == fetchPush);
  assign rowOut.tileLow  = lowByte;
  assign rowOut.tileHigh = highByte;
  assign rowOut.fbAddr   = {{(`VMEM_ADDR_W - `DATA_W - COL_W){1'b0}}, ly, column};

  assign pushDone = rowOut.valid & rowOut.ready;
  assign lastCol  = (column == `TILES_PER_ROW - 1);
  assign lastLine = (ly == `LINES_PER_FRAME - 1);

  //////////////////////////////////////////////////
  // walk fsm and word counters
  //////////////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state  <= fetchIdle;
      phase  <= 1'b0;
      ly     <= '0;
      column <= '0;
    end
    else
    begin
      case (state)
        fetchIdle:
          if (lcdc[7])
            state <= fetchReadMap;  // lcd on
        fetchReadMap:
        begin
          phase <= ~phase;
          if (phase)
            state <= fetchReadLow;
        end
        fetchReadLow:
        begin
          phase <= ~phase;
          if (phase)
            state <= fetchReadHigh;
        end
        fetchReadHigh:
        begin
          phase <= ~phase;
          if (phase)
            state <= fetchPush;
        end
        fetchPush:
          if (pushDone)
          begin
            if (!lcdc[7])
            begin
              state  <= fetchIdle;  // lcd off so park at word 0
              ly     <= '0;
              column <= '0;
            end
            else
            begin
              state  <= fetchReadMap;
              column <= lastCol ? '0 : column + 1'b1;
              if (lastCol)
                ly <= lastLine ? '0 : ly + 1'b1;  // frame wrap
            end
          end
        default: state <= fetchIdle;
      endcase
    end
  end

  // vram bytes land in the capture half of each read state
  always_ff @(posedge clock)
  begin
    if (phase)
    begin
      case (state)
        fetchReadMap:  tileIndex <= vmemData;
        fetchReadLow:  lowByte   <= vmemData;
        fetchReadHigh: highByte  <= vmemData;
        default: ;
      endcase
    end
  end

  // an offered pair holds until the fifo takes it
  validHeld: assert property (@(posedge clock) disable iff (reset)
    rowOut.valid && !rowOut.ready |=> rowOut.valid && $stable(rowOut.fbAddr)
      && $stable(rowOut.tileLow) && $stable(rowOut.tileHigh));

endmodule

// ==== design/tileRowFifo.sv ====
`timescale 1ns/1ps
`include "gpuMacros_macros.svh"

module tileRowFifo
(
  input  logic     clock,
  input  logic     reset,
  tileRowIf.sink   rowIn,   // from the fetcher
  tileRowIf.source rowOut   // to the mapper
);

  localparam int PTR_W   = $clog2(`FIFO_DEPTH);
  localparam int ENTRY_W = `VMEM_ADDR_W + 2*`DATA_W;

  logic [ENTRY_W-1:0] mem [`FIFO_DEPTH];  // {fbAddr, high, low}
  logic [PTR_W-1:0]   wrPtr;
  logic [PTR_W-1:0]   rdPtr;
  logic [PTR_W:0]     count;  // entries held
  logic               push;
  logic               pop;

  // flags come from count only so nothing passes straight through
  assign rowIn.ready  = (count != `FIFO_DEPTH);
  assign rowOut.valid = (count != 0);
  assign push = rowIn.valid & rowIn.ready;
  assign pop  = rowOut.valid & rowOut.ready;

  assign {rowOut.fbAddr, rowOut.tileHigh, rowOut.tileLow} = mem[rdPtr];

  always_ff @(posedge clock)
  begin
    if (push)
      mem[wrPtr] <= {rowIn.fbAddr, rowIn.tileHigh, rowIn.tileLow};
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= (wrPtr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      if (pop)
        rdPtr <= (rdPtr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      if (push != pop)
        count <= push ? count + 1'b1 : count - 1'b1;  // net change only
    end
  end

  // equal pointers mean empty or full, the count tells which
  noPushFull: assert property (@(posedge clock) disable iff (reset)
    push && wrPtr == rdPtr |-> count == 0);
  noPopEmpty: assert property (@(posedge clock) disable iff (reset)
    pop && wrPtr == rdPtr |-> count == `FIFO_DEPTH);

endmodule

// ==== design/paletteMapper.sv ====
`timescale 1ns/1ps
`include "gpuMacros_macros.svh"

module paletteMapper
(
  input  logic                    clock,
  input  logic                    reset,
  input  logic [`DATA_W-1:0]      bgp,
  tileRowIf.sink                  rowIn,
  // frame buffer write port
  output logic                    fbWe,
  output logic [`VMEM_ADDR_W-1:0] fbAddr,
  output logic [`FB_DATA_W-1:0]   fbData,
  input  logic                    fbReady
);

  logic [`FB_DATA_W-1:0] shades;  // eight mapped pixels
  logic                  take;

  assign rowIn.ready = ~fbWe | fbReady;  // room once the pending write drains
  assign take        = rowIn.valid & rowIn.ready;

  // color index {high, low} picks a 2-bit field of bgp
  for (genvar i = 0; i < `DATA_W; i++)
  begin : pixelMap
    assign shades[2*i +: 2] = bgp[{rowIn.tileHigh[i], rowIn.tileLow[i], 1'b0} +: 2];
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      fbWe <= 1'b0;
    else if (take)
      fbWe <= 1'b1;
    else if (fbReady)
      fbWe <= 1'b0;  // write accepted and nothing new
  end

  always_ff @(posedge clock)
  begin
    if (take)
    begin
      fbAddr <= rowIn.fbAddr;
      fbData <= shades;
    end
  end

  fbHold: assert property (@(posedge clock) disable iff (reset)
    fbWe && !fbReady |=> fbWe && $stable(fbAddr) && $stable(fbData));

endmodule

// ==== design/gpuTop.sv ====
`timescale 1ns/1ps
`include "gpuMacros_macros.svh"

module gpuTop
  import gpuPkg::*;
(
  input  logic                    clock,
  input  logic                    reset,
  // apb register port
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [`REG_ADDR_W-1:0]  paddr,
  input  logic [`DATA_W-1:0]      pwdata,
  output logic [`DATA_W-1:0]      prdata,
  output logic                    pready,
  output logic                    pslverr,
  // video memory
  output logic                    vmemRead,
  output logic [`VMEM_ADDR_W-1:0] vmemAddr,
  input  logic [`DATA_W-1:0]      vmemData,
  // frame buffer
  output logic                    fbWe,
  output logic [`VMEM_ADDR_W-1:0] fbAddr,
  output logic [`FB_DATA_W-1:0]   fbData,
  input  logic                    fbReady
);

  logic [`DATA_W-1:0] lcdc;
  logic [`DATA_W-1:0] scy;
  logic [`DATA_W-1:0] scx;
  logic [`DATA_W-1:0] bgp;
  logic [`DATA_W-1:0] ly;
  fetchStateE         fetchState;

  tileRowIf fetchRow ();  // fetcher to fifo
  tileRowIf mapRow ();    // fifo to mapper

  gpuRegisters regs (.clock, .reset, .psel, .penable, .pwrite,
    .paddr(regAddrE'(paddr)), .pwdata, .prdata, .pready, .pslverr,
    .lcdc, .scy, .scx, .bgp, .state(fetchState), .ly);

  tileFetcher fetcher (.clock, .reset, .lcdc, .scy, .scx, .vmemRead, .vmemAddr,
    .vmemData, .rowOut(fetchRow), .state(fetchState), .ly);

  tileRowFifo rowFifo (.clock, .reset, .rowIn(fetchRow), .rowOut(mapRow));

  paletteMapper mapper (.clock, .reset, .bgp, .rowIn(mapRow), .fbWe, .fbAddr,
    .fbData, .fbReady);

endmodule

// ==== verification/tbGpu.sv ====
`timescale 1ns/1ps
`include "gpuMacros_macros.svh"

module tbGpu
  import gpuPkg::*;
();

  localparam int ACCESS_LIMIT = 16;     // cycles allowed for pready
  localparam int WORD_LIMIT   = 20000;  // LY polls allowed while waiting for frame words
  localparam int DRAIN_LIMIT  = 2000;

  logic                    clock;
  logic                    reset;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [`REG_ADDR_W-1:0]  paddr;
  logic [`DATA_W-1:0]      pwdata;
  logic [`DATA_W-1:0]      prdata;
  logic                    pready;
  logic                    pslverr;
  logic                    vmemRead;
  logic [`VMEM_ADDR_W-1:0] vmemAddr;
  logic [`DATA_W-1:0]      vmemData;
  logic                    fbWe;
  logic [`VMEM_ADDR_W-1:0] fbAddr;
  logic [`FB_DATA_W-1:0]   fbData;
  logic                    fbReady;

  logic [31:0]             lfsr;        // fbReady source
  logic [6:0]              stallPhase;  // back-pressure window, low half lets writes through
  int                      wordCount;   // accepted frame writes since the last restart
  logic                    clearCount;
  logic                    lcdOnSeen;   // host has switched the lcd on at least once
  logic [`DATA_W-1:0]      expLcdc;     // config the model renders with
  logic [`DATA_W-1:0]      expScy;
  logic [`DATA_W-1:0]      expScx;
  logic [`DATA_W-1:0]      expBgp;
  logic [`FB_DATA_W-1:0]   expData;
  logic [`DATA_W-1:0]      lastLy;
  int                      errors;
  int                      timeouts;
  logic                    timedOut;

  gpuTop DUT (.clock, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
    .pslverr, .vmemRead, .vmemAddr, .vmemData, .fbWe, .fbAddr, .fbData, .fbReady);

  always #2 clock = ~clock;  // 4 ns period

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  function automatic logic [7:0] vmemByte(input logic [15:0] addr);
    return (addr[15:8] ^ addr[7:0]) + 8'h35;  // contents of the vram model
  endfunction

  function automatic logic lfsrBit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out)
      lfsr = lfsr ^ 32'h80200003;  // taps 32 22 2 1
    return out;
  endfunction

  function automatic logic [15:0] modelWord(input int word, input logic [7:0] lcdcV,
                                            input logic [7:0] scyV, input logic [7:0] scxV,
                                            input logic [7:0] bgpV);
    int          line;
    int          column;
    int          mapAddr;
    int          index;
    int          tileAddr;
    int          rowAddr;
    logic [7:0]  low;
    logic [7:0]  high;
    logic [1:0]  color;
    logic [7:0]  shifted;
    logic [15:0] result;
    line    = (word / `TILES_PER_ROW) % `LINES_PER_FRAME;
    column  = word % `TILES_PER_ROW;
    mapAddr = lcdcV[6] ? `MAP_BASE1 : `MAP_BASE0;
    mapAddr += ((line / 8 + scyV / 8) % 32) * 32 + (column + scxV / 8) % 32;  // scroll wraps
    index   = vmemByte(mapAddr[15:0]);
    if (lcdcV[4])
      tileAddr = `TILE_BASE1 + index * 16;
    else
    begin
      if (index > 127)
        index -= 256;  // signed tile number
      tileAddr = `TILE_BASE0 + index * 16;
    end
    rowAddr = tileAddr + (line % 8) * 2;
    low     = vmemByte(rowAddr[15:0]);
    high    = vmemByte(rowAddr[15:0] + 16'd1);
    for (int i = 0; i < 8; i++)
    begin
      color   = {high[i], low[i]};
      shifted = bgpV >> (2 * color);  // palette field for this color
      result[2*i +: 2] = shifted[1:0];
    end
    return result;
  endfunction

  assign expData = modelWord(wordCount, expLcdc, expScy, expScx, expBgp);

  // vram answers one cycle after the read
  always @(posedge clock)
  begin
    if (vmemRead)
      vmemData <= vmemByte(vmemAddr);
    stallPhase <= stallPhase + 1'b1;
    // one lfsr bit per cycle, held off for long enough to fill the fifo
    fbReady <= reset ? 1'b0 : lfsrBit() & ~stallPhase[6];
  end

  always @(posedge clock)
  begin
    if (reset || clearCount)
      wordCount <= 0;
    else if (fbWe && fbReady)
      wordCount <= wordCount + 1;  // write taken
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////
  addrOrder: assert property (@(posedge clock) disable iff (reset)
    fbWe && fbReady |-> fbAddr == wordCount[15:0])
  else
  begin
    errors++;
    $display("FAIL fbAddr %h expected %h", $sampled(fbAddr), $sampled(wordCount[15:0]));
  end

  dataMatch: assert property (@(posedge clock) disable iff (reset)
    fbWe && fbReady |-> fbData == expData)
  else
  begin
    errors++;
    $display("FAIL fbData %h expected %h at fbAddr %h", $sampled(fbData), $sampled(expData),
      $sampled(fbAddr));
  end

  stallHold: assert property (@(posedge clock) disable iff (reset)
    fbWe && !fbReady |=> fbWe && $stable(fbAddr) && $stable(fbData))
  else
  begin
    errors++;
    $display("frame write changed or dropped while fbReady was low");
  end

  quietWhenOff: assert property (@(posedge clock) disable iff (reset) !lcdOnSeen |-> !fbWe)
  else
  begin
    errors++;
    $display("frame write seen before the lcd was switched on");
  end

  noWaitState: assert property (@(posedge clock) disable iff (reset)
    psel && penable |-> pready)
  else
  begin
    errors++;
    $display("apb access phase saw pready low");
  end

  //////////////////////////////////////////////////
  // host tasks
  //////////////////////////////////////////////////
  task automatic reportTimeout(input string what);
    $display("timeout while waiting for %s", what);
    timeouts++;
    timedOut = 1'b1;  // watchdog ends the run
  endtask

  task automatic apbAccess(input logic write, input logic [3:0] addr, input logic [7:0] wdata,
                           output logic [7:0] rdata, output logic err);
    int waited;
    @(posedge clock);
    psel    <= 1'b1;  // setup phase
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clock);
    penable <= 1'b1;
    waited = 0;
    do
    begin
      @(posedge clock);
      waited++;
    end
    while (!pready && waited < ACCESS_LIMIT);
    rdata = prdata;  // access phase values before this edge's updates
    err   = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
    if (!pready)
      reportTimeout("apb pready");
  endtask

  task automatic checkRead(input logic [3:0] addr, input logic [7:0] expected, input logic expErr);
    logic [7:0] rdata;
    logic       err;
    apbAccess(1'b0, addr, 8'h00, rdata, err);
    assert (err == expErr)
    else
    begin
      errors++;
      $display("FAIL pslverr %h expected %h on read of offset %h", err, expErr, addr);
    end
    assert (expErr || rdata == expected)  // no data promised on an error
    else
    begin
      errors++;
      $display("FAIL prdata %h expected %h at offset %h", rdata, expected, addr);
    end
  endtask

  task automatic checkWrite(input logic [3:0] addr, input logic [7:0] data, input logic expErr);
    logic [7:0] rdata;
    logic       err;
    apbAccess(1'b1, addr, data, rdata, err);
    assert (err == expErr)
    else
    begin
      errors++;
      $display("FAIL pslverr %h expected %h on write of offset %h", err, expErr, addr);
    end
  endtask

  // poll LY until enough frame words have gone out
  task automatic runWords(input int count);
    logic [7:0] rdata;
    logic       err;
    int         polls;
    lastLy = '0;
    polls  = 0;
    while (wordCount < count && polls < WORD_LIMIT)
    begin
      apbAccess(1'b0, regLy, 8'h00, rdata, err);
      assert (rdata >= lastLy)
      else
      begin
        errors++;
        $display("FAIL LY %h below earlier %h", rdata, lastLy);
      end
      lastLy = rdata;
      polls++;
    end
    if (wordCount < count)
      reportTimeout("frame writes");
  endtask

  task automatic waitDrained();
    logic [7:0] rdata;
    logic       err;
    int         tries;
    int         quiet;
    rdata = 8'hFF;
    tries = 0;
    while (rdata != 8'(fetchIdle) && tries < DRAIN_LIMIT)
    begin
      apbAccess(1'b0, regStat, 8'h00, rdata, err);
      tries++;
    end
    if (rdata != 8'(fetchIdle))
      reportTimeout("fetcher idle");
    quiet = 0;
    tries = 0;
    while (quiet < 2 && tries < DRAIN_LIMIT)  // two idle edges mean the fifo is empty
    begin
      @(posedge clock);
      quiet = fbWe ? 0 : quiet + 1;
      tries++;
    end
    if (quiet < 2)
      reportTimeout("frame buffer drain");
  endtask

  task automatic restartAt(input logic [7:0] lcdcValue);
    @(posedge clock);
    clearCount <= 1'b1;
    @(posedge clock);
    clearCount <= 1'b0;
    checkWrite(regLcdc, lcdcValue, 1'b0);
  endtask

  initial
  begin
    wait (timedOut);
    $display("closing counts: %0d frame writes, %0d errors, %0d timeouts", wordCount, errors,
      timeouts);
    $display("Errors found");
    $finish;
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial
  begin
    clock      = 1'b0;
    reset      = 1'b1;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    vmemData   = '0;
    fbReady    = 1'b0;
    lfsr       = 32'd89739;
    stallPhase = '0;
    clearCount = 1'b0;
    lcdOnSeen  = 1'b0;
    expLcdc    = '0;
    expScy     = '0;
    expScx     = '0;
    expBgp     = '0;
    lastLy     = '0;
    errors     = 0;
    timeouts   = 0;
    timedOut   = 1'b0;
    repeat (10) @(posedge clock);
    reset <= 1'b0;

    // everything reads zero out of reset
    checkRead(regLcdc, 8'h00, 1'b0);
    checkRead(regStat, 8'h00, 1'b0);
    checkRead(regScy, 8'h00, 1'b0);
    checkRead(regScx, 8'h00, 1'b0);
    checkRead(regLy, 8'h00, 1'b0);
    checkRead(regBgp, 8'h00, 1'b0);
    checkRead(4'd5, 8'h00, 1'b1);  // hole

    // write and read back with the lcd still off
    checkWrite(regScy, 8'h5A, 1'b0);
    checkWrite(regScx, 8'hA7, 1'b0);
    checkWrite(regBgp, 8'h1B, 1'b0);
    checkWrite(regLcdc, 8'h10, 1'b0);
    checkRead(regScy, 8'h5A, 1'b0);
    checkRead(regScx, 8'hA7, 1'b0);
    checkRead(regBgp, 8'h1B, 1'b0);
    checkRead(regLcdc, 8'h10, 1'b0);
    checkWrite(regStat, 8'hFF, 1'b1);  // read only
    checkWrite(regLy, 8'hFF, 1'b1);
    checkWrite(4'd5, 8'hFF, 1'b1);
    checkRead(regStat, 8'h00, 1'b0);
    checkRead(regLy, 8'h00, 1'b0);
    checkRead(regLcdc, 8'h10, 1'b0);
    checkRead(regScy, 8'h5A, 1'b0);
    checkRead(regScx, 8'hA7, 1'b0);
    checkRead(regBgp, 8'h1B, 1'b0);

    // map 0 and unsigned tile data without scroll
    expLcdc = 8'h90;
    expScy  = 8'h00;
    expScx  = 8'h00;
    expBgp  = 8'hE4;
    checkWrite(regScy, expScy, 1'b0);
    checkWrite(regScx, expScx, 1'b0);
    checkWrite(regBgp, expBgp, 1'b0);
    lcdOnSeen = 1'b1;
    restartAt(8'h90);
    runWords(300);
    checkWrite(regLcdc, 8'h10, 1'b0);  // off, same map and tile set
    waitDrained();

    // map 1 and signed tile data with both scrolls and a shuffled palette
    expLcdc = 8'hC0;
    expScy  = 8'h3B;
    expScx  = 8'h9D;
    expBgp  = 8'h9C;
    checkWrite(regScy, expScy, 1'b0);
    checkWrite(regScx, expScx, 1'b0);
    checkWrite(regBgp, expBgp, 1'b0);
    checkRead(regLy, 8'h00, 1'b0);
    restartAt(8'hC0);
    runWords(300);

    // off in mid frame, then back on from word 0
    checkWrite(regLcdc, 8'h40, 1'b0);
    waitDrained();
    checkRead(regStat, 8'h00, 1'b0);
    checkRead(regLy, 8'h00, 1'b0);
    restartAt(8'hC0);
    runWords(40);

    $display("closing counts: %0d frame writes, %0d errors, %0d timeouts", wordCount, errors,
      timeouts);
    if (errors == 0 && timeouts == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+design
design/gpuPkg.sv
design/tileRowIf.sv
design/gpuRegisters.sv
design/tileFetcher.sv
design/tileRowFifo.sv
design/paletteMapper.sv
design/gpuTop.sv
verification/tbGpu.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tbGpu -o simGpu
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/simGpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

grep -qx "No errors" sim.log || exit 1
exit 0
